/* rtl/ex_pkg.sv */
`default_nettype none

package ex_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int xlen      = 64;            // datapath width
  localparam int ir_w      = 32;            // instruction word
  localparam int ar_idx_w  = 5;             // architectural reg index
  localparam int pr_idx_w  = 7;             // physical reg index
  localparam int num_lanes = 2;             // issue width
  localparam int shamt_w   = $clog2(xlen);  // shift amount bits from opb

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // alu function, codes 0x10 and up are undefined
  typedef enum logic [4:0] {
    alu_addq   = 5'h00,
    alu_subq   = 5'h01,
    alu_and    = 5'h02,
    alu_bic    = 5'h03,  // a & ~b
    alu_bis    = 5'h04,  // a | b
    alu_ornot  = 5'h05,
    alu_xor    = 5'h06,
    alu_eqv    = 5'h07,  // a ^ ~b
    alu_srl    = 5'h08,
    alu_sll    = 5'h09,
    alu_sra    = 5'h0a,
    alu_cmpult = 5'h0b,
    alu_cmpeq  = 5'h0c,
    alu_cmpule = 5'h0d,
    alu_cmplt  = 5'h0e,
    alu_cmple  = 5'h0f
  } alu_func_e;

  // operand a source
  typedef enum logic [1:0] {
    opa_rega     = 2'h0,
    opa_mem_disp = 2'h1,
    opa_npc      = 2'h2,
    opa_not3     = 2'h3   // ~3, aligns a branch target
  } opa_sel_e;

  // operand b source, code 3 unused
  typedef enum logic [1:0] {
    opb_regb    = 2'h0,
    opb_alu_imm = 2'h1,
    opb_br_disp = 2'h2
  } opb_sel_e;

  ////////////////////////////////////////
  // lane records
  ////////////////////////////////////////

  // one instruction from the reservation station
  typedef struct packed {
    logic                valid;
    logic [xlen-1:0]     npc;           // pc + 4
    logic [ir_w-1:0]     ir;
    logic [xlen-1:0]     rega;          // prf read port a
    logic [xlen-1:0]     regb;          // prf read port b
    logic [ar_idx_w-1:0] dest_ar;
    logic [pr_idx_w-1:0] dest_pr;
    opa_sel_e            opa_sel;
    opb_sel_e            opb_sel;
    alu_func_e           func;
    logic                cond_branch;
    logic                uncond_branch;
    logic                pred_taken;    // fetch-time prediction
    logic [xlen-1:0]     pred_addr;
  } ex_issue_t;

  // one completed instruction, to cdb and prf write port
  typedef struct packed {
    logic                complete;
    logic [ar_idx_w-1:0] dest_ar;
    logic [pr_idx_w-1:0] dest_pr;
    logic [xlen-1:0]     result;
    logic                write_enable;
    logic                exception;     // undefined alu func
    logic                taken;
    logic [xlen-1:0]     target;
    logic                mispredict;
  } ex_result_t;

endpackage

`default_nettype wire

/* rtl/ex_operand_select.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_operand_select (
  input  ex_pkg::ex_issue_t        issue,
  output logic [ex_pkg::xlen-1:0]  opa,
  output logic [ex_pkg::xlen-1:0]  opb
);

  import ex_pkg::*;

  logic [xlen-1:0] mem_disp;  // memory format displacement
  logic [xlen-1:0] br_disp;   // branch displacement in bytes
  logic [xlen-1:0] alu_imm;   // 8-bit literal

  ////////////////////////////////////////
  // immediates
  ////////////////////////////////////////

  // sign extend ir[15:0]
  assign mem_disp = {{(xlen-16){issue.ir[15]}}, issue.ir[15:0]};

  // sign extend ir[20:0], then word to byte offset
  assign br_disp  = {{(xlen-23){issue.ir[20]}}, issue.ir[20:0], 2'b00};

  assign alu_imm  = {{(xlen-8){1'b0}}, issue.ir[20:13]};  // zero extended

  ////////////////////////////////////////
  // operand muxes
  ////////////////////////////////////////

  always_comb
  begin
    case (issue.opa_sel)
      opa_rega:     opa = issue.rega;
      opa_mem_disp: opa = mem_disp;    // ldah/lda style
      opa_npc:      opa = issue.npc;   // pc-relative branches
      opa_not3:     opa = ~xlen'(3);   // masks jump target
      default:      opa = '0;
    endcase
  end

  always_comb
  begin
    case (issue.opb_sel)
      opb_regb:    opb = issue.regb;
      opb_alu_imm: opb = alu_imm;
      opb_br_disp: opb = br_disp;
      default:     opb = '0;           // unused code reads as zero
    endcase
  end

endmodule

`default_nettype wire

/* rtl/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  logic [ex_pkg::xlen-1:0]  opa,
  input  logic [ex_pkg::xlen-1:0]  opb,
  input  ex_pkg::alu_func_e        func,
  output logic [ex_pkg::xlen-1:0]  result,
  output logic                     illegal
);

  import ex_pkg::*;

  logic [shamt_w-1:0] shamt;  // low bits of opb only
  logic               ult;    // unsigned a < b
  logic               eq;
  logic               slt;    // signed a < b

  assign shamt = opb[shamt_w-1:0];

  ////////////////////////////////////////
  // compare terms
  ////////////////////////////////////////

  assign ult = (opa < opb);
  assign eq  = (opa == opb);

  // same sign, unsigned order holds; else the negative one is smaller
  assign slt = (opa[xlen-1] == opb[xlen-1]) ? ult : opa[xlen-1];

  ////////////////////////////////////////
  // function mux
  ////////////////////////////////////////

  always_comb
  begin
    illegal = 1'b0;
    case (func)
      alu_addq:   result = opa + opb;
      alu_subq:   result = opa - opb;
      alu_and:    result = opa & opb;
      alu_bic:    result = opa & ~opb;
      alu_bis:    result = opa | opb;
      alu_ornot:  result = opa | ~opb;
      alu_xor:    result = opa ^ opb;
      alu_eqv:    result = opa ^ ~opb;
      alu_srl:    result = opa >> shamt;
      alu_sll:    result = opa << shamt;
      alu_sra:    result = $unsigned($signed(opa) >>> shamt);  // sign fill
      // compares land in bit 0
      alu_cmpult: result = xlen'(ult);
      alu_cmpeq:  result = xlen'(eq);
      alu_cmpule: result = xlen'(ult | eq);
      alu_cmplt:  result = xlen'(slt);
      alu_cmple:  result = xlen'(slt | eq);
      default:
      begin
        result  = '0;     // undefined func, no value
        illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/ex_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit (
  input  ex_pkg::ex_issue_t        issue,
  input  logic [ex_pkg::xlen-1:0]  alu_result,  // computed target
  output logic                     taken,
  output logic [ex_pkg::xlen-1:0]  target,
  output logic                     mispredict
);

  import ex_pkg::*;

  logic       cond_raw;   // before the ir[28] invert
  logic       cond;
  logic       is_branch;
  logic [2:0] cond_code;  // ir[28:26]

  assign cond_code = issue.ir[28:26];

  ////////////////////////////////////////
  // condition on rega
  ////////////////////////////////////////

  always_comb
  begin
    case (cond_code[1:0])
      2'b00:   cond_raw = ~issue.rega[0];                          // lbc
      2'b01:   cond_raw = (issue.rega == '0);                      // eq
      2'b10:   cond_raw = issue.rega[xlen-1];                      // lt
      default: cond_raw = issue.rega[xlen-1] | (issue.rega == '0); // le
    endcase
  end

  assign cond = cond_raw ^ cond_code[2];  // lbs, ne, ge, gt

  ////////////////////////////////////////
  // resolve
  ////////////////////////////////////////

  assign is_branch = issue.cond_branch | issue.uncond_branch;
  assign taken     = issue.uncond_branch | (issue.cond_branch & cond);
  assign target    = taken ? alu_result : issue.npc;  // fall through to npc

  // wrong direction or wrong address
  assign mispredict = issue.valid & is_branch
                    & ((taken != issue.pred_taken) | (target != issue.pred_addr));

endmodule

`default_nettype wire

/* rtl/ex_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_lane (
  input  logic               clock,
  input  logic               reset,
  input  ex_pkg::ex_issue_t  issue,
  output ex_pkg::ex_result_t result
);

  import ex_pkg::*;

  logic [xlen-1:0] opa;
  logic [xlen-1:0] opb;
  logic [xlen-1:0] alu_result;
  logic            illegal;
  logic            br_taken;
  logic [xlen-1:0] br_target;
  logic            br_mispredict;
  ex_result_t      result_next;  // d side of the output register

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////

  ex_operand_select u_operand_select (
    .issue (issue),
    .opa   (opa),
    .opb   (opb)
  );

  ex_alu u_alu (
    .opa     (opa),
    .opb     (opb),
    .func    (issue.func),
    .result  (alu_result),
    .illegal (illegal)
  );

  // condition always tested on rega, not on the muxed opa
  ex_branch_unit u_branch_unit (
    .issue      (issue),
    .alu_result (alu_result),
    .taken      (br_taken),
    .target     (br_target),
    .mispredict (br_mispredict)
  );

  ////////////////////////////////////////
  // result assembly
  ////////////////////////////////////////

  always_comb
  begin
    result_next.complete     = issue.valid;
    result_next.dest_ar      = issue.dest_ar;  // passed through as is
    result_next.dest_pr      = issue.dest_pr;
    result_next.result       = illegal ? '0 : alu_result;
    result_next.write_enable = issue.valid & ~illegal;
    result_next.exception    = issue.valid & illegal;
    result_next.taken        = br_taken;
    result_next.target       = br_target;
    result_next.mispredict   = br_mispredict;  // already qualified by valid
  end

  // one cycle, no stall
  always_ff @(posedge clock)
  begin
    if (reset)
      result <= '0;
    else
      result <= result_next;
  end

endmodule

`default_nettype wire

/* rtl/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic                                           clock,
  input  logic                                           reset,
  input  ex_pkg::ex_issue_t  [ex_pkg::num_lanes-1:0]     issue,
  output ex_pkg::ex_result_t [ex_pkg::num_lanes-1:0]     result,
  output logic               [ex_pkg::num_lanes-1:0]     alu_avail
);

  import ex_pkg::*;

  ////////////////////////////////////////
  // lanes
  ////////////////////////////////////////

  // lanes run independently, same latency
  for (genvar i = 0; i < num_lanes; i++)
  begin : g_lane
    ex_lane u_lane (
      .clock  (clock),
      .reset  (reset),
      .issue  (issue[i]),
      .result (result[i])
    );
  end

  ////////////////////////////////////////
  // availability to the rs
  ////////////////////////////////////////

  // no back-pressure, every lane free once out of reset
  always_ff @(posedge clock)
  begin
    if (reset)
      alu_avail <= '0;
    else
      alu_avail <= '1;
  end

endmodule

`default_nettype wire

/* verification/ex_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;

  import ex_pkg::*;

  localparam int clock_period = 10;
  localparam int reset_time   = 5 * clock_period;  // reset plus some slack

  // one stimulus row, may go to either lane
  typedef struct packed {
    logic        valid;
    logic [4:0]  func;          // raw code, undefined ones allowed
    logic [1:0]  opa_sel;
    logic [1:0]  opb_sel;
    logic [31:0] ir;
    logic        cond_branch;
    logic        uncond_branch;
    logic        pred_taken;
    logic        pred_addr_ok;  // predict the resolved target
    logic [1:0]  edge_a;        // 0 random, 1 zero, 2 all ones, 3 sign bit
    logic [1:0]  edge_b;
  } row_t;

  typedef ex_result_t [num_lanes-1:0] result_vec_t;

  logic                       clock;
  logic                       reset;
  ex_issue_t  [num_lanes-1:0] issue;
  ex_result_t [num_lanes-1:0] result;
  logic       [num_lanes-1:0] alu_avail;

  row_t        rows[$];
  result_vec_t exp_q[$];     // one entry per issue cycle
  logic [31:0] rng_state;
  bit          table_ready;
  int          errors;
  int          checks;
  int          step_errors;
  int          row1;         // row sent to lane 1
  int          prev_row1;
  ex_issue_t   iss0;
  ex_issue_t   iss1;

  ex_stage u_ex_stage (
    .clock     (clock),
    .reset     (reset),
    .issue     (issue),
    .result    (result),
    .alu_avail (alu_avail)
  );

  always #(clock_period / 2) clock = ~clock;

  ////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = xorshift32();
    lo = xorshift32();
    return {hi, lo};
  endfunction

  function automatic logic [63:0] edge_value(input logic [1:0] sel, input logic [63:0] rnd);
    case (sel)
      2'd1:    return '0;
      2'd2:    return '1;
      2'd3:    return 64'h8000_0000_0000_0000;  // most negative
      default: return rnd;
    endcase
  endfunction

  function automatic ex_result_t model(input ex_issue_t in);
    ex_result_t  res;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] alu;
    logic        bad;
    logic        cond;
    int unsigned sh;
    bad = 1'b0;
    case (in.opa_sel)
      opa_rega:     a = in.rega;
      opa_mem_disp: a = 64'($signed(in.ir[15:0]));
      opa_npc:      a = in.npc;
      default:      a = 64'hffff_ffff_ffff_fffc;  // not3
    endcase
    case (in.opb_sel)
      opb_regb:    b = in.regb;
      opb_alu_imm: b = 64'(in.ir[20:13]);
      opb_br_disp: b = 64'($signed(in.ir[20:0])) * 4;  // words to bytes
      default:     b = '0;
    endcase
    sh = b % 64;
    case (in.func)
      alu_addq:   alu = a + b;
      alu_subq:   alu = a - b;
      alu_and:    alu = a & b;
      alu_bic:    alu = a & ~b;
      alu_bis:    alu = a | b;
      alu_ornot:  alu = a | ~b;
      alu_xor:    alu = a ^ b;
      alu_eqv:    alu = ~(a ^ b);
      alu_srl:    alu = a >> sh;
      alu_sll:    alu = a << sh;
      alu_sra:    alu = a[63] ? ((a >> sh) | ~({64{1'b1}} >> sh)) : (a >> sh);
      alu_cmpult: alu = (a < b) ? 64'd1 : 64'd0;
      alu_cmpeq:  alu = (a == b) ? 64'd1 : 64'd0;
      alu_cmpule: alu = (a <= b) ? 64'd1 : 64'd0;
      alu_cmplt:  alu = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      alu_cmple:  alu = ($signed(a) <= $signed(b)) ? 64'd1 : 64'd0;
      default:
      begin
        alu = '0;
        bad = 1'b1;
      end
    endcase
    case (in.ir[28:26])
      3'd0:    cond = ~in.rega[0];               // blbc
      3'd1:    cond = (in.rega == 0);            // beq
      3'd2:    cond = ($signed(in.rega) < 0);    // blt
      3'd3:    cond = ($signed(in.rega) <= 0);   // ble
      3'd4:    cond = in.rega[0];                // blbs
      3'd5:    cond = (in.rega != 0);            // bne
      3'd6:    cond = ($signed(in.rega) >= 0);   // bge
      default: cond = ($signed(in.rega) > 0);    // bgt
    endcase
    res.complete     = in.valid;
    res.dest_ar      = in.dest_ar;
    res.dest_pr      = in.dest_pr;
    res.result       = bad ? 64'd0 : alu;
    res.write_enable = in.valid && !bad;
    res.exception    = in.valid && bad;
    res.taken        = in.uncond_branch || (in.cond_branch && cond);
    res.target       = res.taken ? alu : in.npc;
    res.mispredict   = in.valid && (in.cond_branch || in.uncond_branch)
                       && (res.taken != in.pred_taken || res.target != in.pred_addr);
    return res;
  endfunction

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic build_table();
    row_t        r;
    logic [31:0] w;
    // every legal func under every operand source, opb code 3 too
    for (int f = 0; f < 16; f++)
      for (int a = 0; a < 4; a++)
        for (int b = 0; b < 4; b++)
        begin
          r = '0;
          r.valid = 1'b1;
          r.func = 5'(f);
          r.opa_sel = 2'(a);
          r.opb_sel = 2'(b);
          r.ir = xorshift32();
          r.pred_taken = 1'(f % 2);  // non-branch, must never mispredict
          r.edge_a = 2'((f + a) % 4);
          r.edge_b = 2'((f + 2 * b + a) % 4);
          rows.push_back(r);
        end
    // conditional branches, all eight codes against edge rega values
    for (int c = 0; c < 8; c++)
      for (int e = 0; e < 4; e++)
      begin
        w = xorshift32();
        r = '0;
        r.valid = 1'b1;
        r.func = alu_addq;
        r.opa_sel = opa_npc;
        r.opb_sel = opb_br_disp;
        r.ir = {3'b011, 3'(c), w[25:0]};
        r.cond_branch = 1'b1;
        r.pred_taken = 1'((e / 2 + c) % 2);
        r.pred_addr_ok = 1'(e % 2);
        r.edge_a = 2'(e);
        rows.push_back(r);
      end
    // jmp style (regb & ~3) then bsr style (npc + disp)
    for (int e = 0; e < 6; e++)
    begin
      r = '0;
      r.valid = 1'b1;
      r.func = (e < 4) ? alu_and : alu_addq;
      r.opa_sel = (e < 4) ? opa_not3 : opa_npc;
      r.opb_sel = (e < 4) ? opb_regb : opb_br_disp;
      r.ir = xorshift32();
      r.uncond_branch = 1'b1;
      r.pred_taken = 1'((e / 2) % 2);
      r.pred_addr_ok = 1'(e % 2);
      rows.push_back(r);
    end
    // undefined funcs and dropped issues
    for (int e = 0; e < 8; e++)
    begin
      r = '0;
      r.valid = (e < 5);
      r.func = (e < 6) ? 5'(16 + 3 * e) : alu_addq;
      r.ir = xorshift32();
      r.cond_branch = (e % 3 == 1);
      r.pred_taken = 1'(e % 2);
      r.edge_a = 2'(e % 4);
      rows.push_back(r);
    end
  endtask

  task automatic make_issue(input row_t r, input int tag, output ex_issue_t iss);
    ex_result_t probe;
    iss = '0;
    iss.valid = r.valid;
    iss.npc = rand64() & ~64'h3;  // word aligned
    iss.ir = r.ir;
    iss.rega = edge_value(r.edge_a, rand64());
    iss.regb = edge_value(r.edge_b, rand64());
    iss.dest_ar = ar_idx_w'(tag);
    iss.dest_pr = pr_idx_w'(tag * 3 + 1);
    iss.opa_sel = opa_sel_e'(r.opa_sel);
    iss.opb_sel = opb_sel_e'(r.opb_sel);
    iss.func = alu_func_e'(r.func);
    iss.cond_branch = r.cond_branch;
    iss.uncond_branch = r.uncond_branch;
    iss.pred_taken = r.pred_taken;
    probe = model(iss);
    iss.pred_addr = r.pred_addr_ok ? probe.target : probe.target ^ 64'h40;  // off by 16 words
  endtask

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic compare_field(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      step_errors++;
      $display("[ERROR] %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_step();
    result_vec_t exp;
    string       p;
    step_errors = 0;
    exp = exp_q.pop_front();
    compare_field("alu_avail", 64'({num_lanes{1'b1}}), 64'(alu_avail));
    for (int l = 0; l < num_lanes; l++)
    begin
      p = $sformatf("result[%0d]", l);
      compare_field({p, ".complete"}, exp[l].complete, result[l].complete);
      compare_field({p, ".dest_ar"}, exp[l].dest_ar, result[l].dest_ar);
      compare_field({p, ".dest_pr"}, exp[l].dest_pr, result[l].dest_pr);
      compare_field({p, ".result"}, exp[l].result, result[l].result);
      compare_field({p, ".write_enable"}, exp[l].write_enable, result[l].write_enable);
      compare_field({p, ".exception"}, exp[l].exception, result[l].exception);
      compare_field({p, ".taken"}, exp[l].taken, result[l].taken);
      compare_field({p, ".target"}, exp[l].target, result[l].target);
      compare_field({p, ".mispredict"}, exp[l].mispredict, result[l].mispredict);
    end
  endtask

  ////////////////////////////////////////
  // main flow
  ////////////////////////////////////////

  initial
  begin
    clock = 1'b0;
    reset = 1'b1;
    issue = '0;
    rng_state = 32'h741e060e;
    errors = 0;
    checks = 0;
    prev_row1 = 0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    step_errors = 0;
    compare_field("alu_avail", 64'd0, 64'(alu_avail));  // still in reset
    for (int l = 0; l < num_lanes; l++)
      compare_field($sformatf("result[%0d] flags", l), 64'd0,
                    64'({result[l].complete, result[l].write_enable,
                         result[l].exception, result[l].mispredict}));
    $display("reset state: %s", (step_errors != 0) ? "mismatch" : "ok");
    @(posedge clock);
    reset <= 1'b0;                            // third edge still sees reset
    exp_q.push_back({model('0), model('0)});  // idle issue in flight
    // lane 1 runs the table half a turn behind lane 0
    for (int s = 0; s <= rows.size(); s++)
    begin
      @(posedge clock);
      if (s < rows.size())
      begin
        row1 = (s + rows.size() / 2) % rows.size();
        make_issue(rows[s], 2 * s, iss0);
        make_issue(rows[row1], 2 * s + 1, iss1);
        issue[0] <= iss0;
        issue[1] <= iss1;
        exp_q.push_back({model(iss1), model(iss0)});
      end
      else
        issue <= '0;
      @(negedge clock);                       // registered outputs settled
      check_step();
      if (s == 0)
        $display("idle cycle after reset: %s", (step_errors != 0) ? "mismatch" : "ok");
      else
        $display("step %0d rows %0d/%0d: %s", s - 1, s - 1, prev_row1,
                 (step_errors != 0) ? "mismatch" : "ok");
      prev_row1 = row1;
    end
    $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // watchdog, four clocks per row plus reset
  initial
  begin
    wait (table_ready);
    #(rows.size() * clock_period * 4 + reset_time);
    $display("timeout: the stimulus table did not finish in the expected time");
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
rtl/ex_pkg.sv
rtl/ex_operand_select.sv
rtl/ex_alu.sv
rtl/ex_branch_unit.sv
rtl/ex_lane.sv
rtl/ex_stage.sv
verification/ex_stage_tb.sv
